// File: source/demux_macros.svh
`ifndef DEMUX_MACROS_SVH
`define DEMUX_MACROS_SVH

// number of downstream master ports
`define DEMUX_NUM_MST 4
// full AXI ID width
`define DEMUX_ID_WIDTH 4
// low ID bits used to index the in-flight counters
`define DEMUX_LOOK_BITS 2
// payload widths
`define DEMUX_ADDR_WIDTH 32
`define DEMUX_DATA_WIDTH 32
// burst length field, a burst carries len+1 beats
`define DEMUX_LEN_WIDTH 4
// in-flight counter width, full at all ones
`define DEMUX_CNT_WIDTH 3

`endif

// File: source/demux_pkg.sv
`default_nettype none

`include "demux_macros.svh"

package demux_pkg;

  // ------------------------------------------------
  // scalar types
  // ------------------------------------------------

  // complete AXI ID
  typedef logic [`DEMUX_ID_WIDTH-1:0] axi_id_t;
  // index into the in-flight counter bank
  typedef logic [`DEMUX_LOOK_BITS-1:0] look_id_t;
  // master port index
  typedef logic [$clog2(`DEMUX_NUM_MST)-1:0] mst_sel_t;
  // number of bursts in flight for one counter index
  typedef logic [`DEMUX_CNT_WIDTH-1:0] in_flight_t;

  typedef logic [`DEMUX_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`DEMUX_DATA_WIDTH-1:0] data_t;
  typedef logic [`DEMUX_LEN_WIDTH-1:0] len_t;

  // ------------------------------------------------
  // channel payloads
  // ------------------------------------------------

  // read address request
  typedef struct packed {
    axi_id_t id;
    addr_t   addr;
    len_t    len;
  } ar_chan_t;

  // read data beat
  typedef struct packed {
    axi_id_t id;
    data_t   data;
    logic    last;
  } r_chan_t;

endpackage

`default_nettype wire

// File: source/ar_id_tracker.sv
`default_nettype none

`include "demux_macros.svh"

module ar_id_tracker
  import demux_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     arst_n_i,
  // lookup for the AR waiting at the slave port
  input  wire look_id_t lookup_id_i,
  output mst_sel_t      lookup_sel_o,
  output logic          lookup_occupied_o,
  output logic          full_o,
  // AR accepted by a master port
  input  wire logic     push_i,
  input  wire look_id_t push_id_i,
  input  wire mst_sel_t push_sel_i,
  // last R beat handed upstream
  input  wire logic     pop_i,
  input  wire look_id_t pop_id_i
);

  // one counter per value of the low ID bits
  localparam int unsigned NUM_CNT = 2 ** `DEMUX_LOOK_BITS;

  mst_sel_t   [NUM_CNT-1:0] cnt_sel;
  logic       [NUM_CNT-1:0] occupied;
  logic       [NUM_CNT-1:0] cnt_full;

  // ------------------------------------------------
  // lookup
  // ------------------------------------------------

  // port the looked-up index is bound to, only meaningful while occupied
  assign lookup_sel_o      = cnt_sel[lookup_id_i];
  assign lookup_occupied_o = occupied[lookup_id_i];
  // any saturated counter blocks all new requests
  assign full_o            = |cnt_full;

  // ------------------------------------------------
  // counter bank
  // ------------------------------------------------

  for (genvar i = 0; i < NUM_CNT; i++) begin : gen_cnt
    logic       push_hit;
    logic       pop_hit;
    in_flight_t cnt_q;
    mst_sel_t   sel_q;

    assign push_hit = push_i && (push_id_i == look_id_t'(i));
    assign pop_hit  = pop_i && (pop_id_i == look_id_t'(i));

    // push and pop on the same index leave the count unchanged
    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        cnt_q <= '0;
      end else if (push_hit && !pop_hit) begin
        cnt_q <= cnt_q + in_flight_t'(1);
      end else if (pop_hit && !push_hit) begin
        cnt_q <= cnt_q - in_flight_t'(1);
      end
    end

    // port of the most recent request on this index
    always_ff @(posedge clk_i) begin
      if (push_hit) begin
        sel_q <= push_sel_i;
      end
    end

    assign cnt_sel[i]  = sel_q;
    assign occupied[i] = |cnt_q;
    // saturated at the all-ones value
    assign cnt_full[i] = &cnt_q;
  end

endmodule

`default_nettype wire

// File: source/ar_route_ctrl.sv
`default_nettype none

`include "demux_macros.svh"

module ar_route_ctrl
  import demux_pkg::*;
(
  // upstream AR
  input  wire ar_chan_t                  slv_ar_i,
  input  wire mst_sel_t                  slv_ar_sel_i,
  input  wire logic                      slv_ar_valid_i,
  output logic                           slv_ar_ready_o,
  // downstream AR, payload shared by all ports
  output ar_chan_t                       mst_ar_o,
  output logic     [`DEMUX_NUM_MST-1:0]  mst_ar_valid_o,
  input  wire logic [`DEMUX_NUM_MST-1:0] mst_ar_ready_i,
  // tracker interface
  output look_id_t                       lookup_id_o,
  input  wire mst_sel_t                  lookup_sel_i,
  input  wire logic                      lookup_occupied_i,
  input  wire logic                      full_i,
  output logic                           push_o,
  output mst_sel_t                       push_sel_o
);

  localparam int unsigned NUM_MST = `DEMUX_NUM_MST;

  logic id_free;
  logic admit;

  // ------------------------------------------------
  // admission
  // ------------------------------------------------

  // counter index comes from the low ID bits
  assign lookup_id_o = slv_ar_i.id[`DEMUX_LOOK_BITS-1:0];

  // idle ID or ID already bound to the requested port
  assign id_free = !lookup_occupied_i || (lookup_sel_i == slv_ar_sel_i);

  // stall conditions only relax while waiting, so valid never drops early
  assign admit = slv_ar_valid_i && !full_i && id_free;

  // ------------------------------------------------
  // valid/ready decode
  // ------------------------------------------------

  assign mst_ar_o = slv_ar_i;

  // valid goes to the selected port only
  always_comb begin
    mst_ar_valid_o = '0;
    for (int unsigned i = 0; i < NUM_MST; i++) begin
      mst_ar_valid_o[i] = admit && (slv_ar_sel_i == mst_sel_t'(i));
    end
  end

  // ready returns from the selected port
  assign slv_ar_ready_o = admit && mst_ar_ready_i[slv_ar_sel_i];

  // count the burst on the handshake
  assign push_o     = slv_ar_ready_o;
  assign push_sel_o = slv_ar_sel_i;

endmodule

`default_nettype wire

// File: source/r_rr_arbiter.sv
`default_nettype none

`include "demux_macros.svh"

module r_rr_arbiter
  import demux_pkg::*;
(
  input  wire logic                      clk_i,
  input  wire logic                      arst_n_i,
  // R streams from the master ports
  input  wire r_chan_t [`DEMUX_NUM_MST-1:0] mst_r_i,
  input  wire logic [`DEMUX_NUM_MST-1:0] mst_r_valid_i,
  output logic     [`DEMUX_NUM_MST-1:0]  mst_r_ready_o,
  // merged R stream upstream
  output r_chan_t                        slv_r_o,
  output logic                           slv_r_valid_o,
  input  wire logic                      slv_r_ready_i,
  // burst completion for the tracker
  output logic                           pop_o,
  output look_id_t                       pop_id_o
);

  localparam int unsigned NUM_MST = `DEMUX_NUM_MST;

  // round-robin pointer, highest priority port
  mst_sel_t rr_q;
  // grant held while the granted beat waits
  logic     lock_q;
  mst_sel_t lock_idx_q;

  mst_sel_t scan_idx;
  mst_sel_t pick_idx;
  logic     pick_found;
  mst_sel_t grant_idx;
  logic     r_hs;

  // ------------------------------------------------
  // port search
  // ------------------------------------------------

  // first valid port at or after the pointer, wrapping around
  always_comb begin
    pick_idx   = rr_q;
    pick_found = 1'b0;
    scan_idx   = rr_q;
    for (int unsigned k = 0; k < NUM_MST; k++) begin
      scan_idx = mst_sel_t'((rr_q + k) % NUM_MST);
      if (!pick_found && mst_r_valid_i[scan_idx]) begin
        pick_found = 1'b1;
        pick_idx   = scan_idx;
      end
    end
  end

  // locked grant wins over a fresh search
  assign grant_idx     = lock_q ? lock_idx_q : pick_idx;
  assign slv_r_valid_o = lock_q ? mst_r_valid_i[lock_idx_q] : pick_found;
  assign slv_r_o       = mst_r_i[grant_idx];

  assign r_hs = slv_r_valid_o && slv_r_ready_i;

  // ready only to the granted port, and only when upstream takes the beat
  always_comb begin
    mst_r_ready_o            = '0;
    mst_r_ready_o[grant_idx] = r_hs;
  end

  // ------------------------------------------------
  // pointer and lock-in
  // ------------------------------------------------

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (r_hs) begin
      // winner drops to lowest priority
      rr_q   <= mst_sel_t'((grant_idx + 1) % NUM_MST);
      lock_q <= 1'b0;
    end else if (slv_r_valid_o) begin
      // beat offered but not taken
      lock_q     <= 1'b1;
      lock_idx_q <= grant_idx;
    end
  end

  // burst done once its last beat leaves upstream
  assign pop_o    = r_hs && slv_r_o.last;
  assign pop_id_o = slv_r_o.id[`DEMUX_LOOK_BITS-1:0];

endmodule

`default_nettype wire

// File: source/read_demux_top.sv
`default_nettype none

`include "demux_macros.svh"

module read_demux_top
  import demux_pkg::*;
(
  input  wire logic                         clk_i,
  input  wire logic                         arst_n_i,
  // upstream port
  input  wire ar_chan_t                     slv_ar_i,
  input  wire mst_sel_t                     slv_ar_sel_i,
  input  wire logic                         slv_ar_valid_i,
  output logic                              slv_ar_ready_o,
  output r_chan_t                           slv_r_o,
  output logic                              slv_r_valid_o,
  input  wire logic                         slv_r_ready_i,
  // downstream ports
  output ar_chan_t                          mst_ar_o,
  output logic     [`DEMUX_NUM_MST-1:0]     mst_ar_valid_o,
  input  wire logic [`DEMUX_NUM_MST-1:0]    mst_ar_ready_i,
  input  wire r_chan_t [`DEMUX_NUM_MST-1:0] mst_r_i,
  input  wire logic [`DEMUX_NUM_MST-1:0]    mst_r_valid_i,
  output logic     [`DEMUX_NUM_MST-1:0]     mst_r_ready_o
);

  // tracker lookup
  look_id_t lookup_id;
  mst_sel_t lookup_sel;
  logic     lookup_occupied;
  logic     id_full;
  // tracker updates
  logic     ar_push;
  mst_sel_t ar_push_sel;
  logic     r_pop;
  look_id_t r_pop_id;

  // ------------------------------------------------
  // ID ordering
  // ------------------------------------------------

  // push index is the lookup index of the waiting AR
  ar_id_tracker i_tracker (
    .clk_i             ( clk_i           ),
    .arst_n_i          ( arst_n_i        ),
    .lookup_id_i       ( lookup_id       ),
    .lookup_sel_o      ( lookup_sel      ),
    .lookup_occupied_o ( lookup_occupied ),
    .full_o            ( id_full         ),
    .push_i            ( ar_push         ),
    .push_id_i         ( lookup_id       ),
    .push_sel_i        ( ar_push_sel     ),
    .pop_i             ( r_pop           ),
    .pop_id_i          ( r_pop_id        )
  );

  // ------------------------------------------------
  // AR routing
  // ------------------------------------------------

  ar_route_ctrl i_ar_route (
    .slv_ar_i          ( slv_ar_i        ),
    .slv_ar_sel_i      ( slv_ar_sel_i    ),
    .slv_ar_valid_i    ( slv_ar_valid_i  ),
    .slv_ar_ready_o    ( slv_ar_ready_o  ),
    .mst_ar_o          ( mst_ar_o        ),
    .mst_ar_valid_o    ( mst_ar_valid_o  ),
    .mst_ar_ready_i    ( mst_ar_ready_i  ),
    .lookup_id_o       ( lookup_id       ),
    .lookup_sel_i      ( lookup_sel      ),
    .lookup_occupied_i ( lookup_occupied ),
    .full_i            ( id_full         ),
    .push_o            ( ar_push         ),
    .push_sel_o        ( ar_push_sel     )
  );

  // ------------------------------------------------
  // R merge
  // ------------------------------------------------

  r_rr_arbiter i_r_arb (
    .clk_i         ( clk_i         ),
    .arst_n_i      ( arst_n_i      ),
    .mst_r_i       ( mst_r_i       ),
    .mst_r_valid_i ( mst_r_valid_i ),
    .mst_r_ready_o ( mst_r_ready_o ),
    .slv_r_o       ( slv_r_o       ),
    .slv_r_valid_o ( slv_r_valid_o ),
    .slv_r_ready_i ( slv_r_ready_i ),
    .pop_o         ( r_pop         ),
    .pop_id_o      ( r_pop_id      )
  );

endmodule

`default_nettype wire

// File: sim/tb_read_demux.sv
`default_nettype none

`include "demux_macros.svh"

module tb_read_demux
  import demux_pkg::*;
();

  localparam int unsigned NUM_MST    = `DEMUX_NUM_MST;
  localparam int unsigned NUM_CNT    = 2 ** `DEMUX_LOOK_BITS;
  localparam int unsigned NUM_ID     = 2 ** `DEMUX_ID_WIDTH;
  localparam int unsigned MAX_FLIGHT = 2 ** `DEMUX_CNT_WIDTH - 1;
  localparam int unsigned MAX_REC    = 512;

  logic                       clk_i          = 1'b0;
  logic                       arst_n_i       = 1'b0;
  ar_chan_t                   slv_ar_i       = '0;
  mst_sel_t                   slv_ar_sel_i   = '0;
  logic                       slv_ar_valid_i = 1'b0;
  logic                       slv_ar_ready_o;
  r_chan_t                    slv_r_o;
  logic                       slv_r_valid_o;
  logic                       slv_r_ready_i  = 1'b0;
  ar_chan_t                   mst_ar_o;
  logic [NUM_MST-1:0]         mst_ar_valid_o;
  wire  [NUM_MST-1:0]         mst_ar_ready_i;
  wire  r_chan_t [NUM_MST-1:0] mst_r_i;
  wire  [NUM_MST-1:0]         mst_r_valid_i;
  logic [NUM_MST-1:0]         mst_r_ready_o;

  // per-cycle random enables for the slave models
  logic [NUM_MST-1:0] ar_rdy_rnd = '0;
  logic [NUM_MST-1:0] r_go_rnd   = '0;
  // stops a slave from starting new beats
  logic [NUM_MST-1:0] r_hold     = '0;

  // scoreboard: accepted ARs in order, plus per-ID read position
  ar_chan_t    rec_ar    [MAX_REC];
  mst_sel_t    rec_sel   [MAX_REC];
  int unsigned rec_cnt = 0;
  int unsigned head      [NUM_ID]  = '{default: 0};
  int unsigned beat_no   [NUM_ID]  = '{default: 0};
  int unsigned outst     [NUM_CNT] = '{default: 0};
  mst_sel_t    bound     [NUM_CNT] = '{default: '0};
  int unsigned requested [NUM_MST] = '{default: 0};
  int unsigned served    [NUM_MST] = '{default: 0};

  always #4 clk_i = ~clk_i;

  read_demux_top dut (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .slv_ar_i       ( slv_ar_i       ),
    .slv_ar_sel_i   ( slv_ar_sel_i   ),
    .slv_ar_valid_i ( slv_ar_valid_i ),
    .slv_ar_ready_o ( slv_ar_ready_o ),
    .slv_r_o        ( slv_r_o        ),
    .slv_r_valid_o  ( slv_r_valid_o  ),
    .slv_r_ready_i  ( slv_r_ready_i  ),
    .mst_ar_o       ( mst_ar_o       ),
    .mst_ar_valid_o ( mst_ar_valid_o ),
    .mst_ar_ready_i ( mst_ar_ready_i ),
    .mst_r_i        ( mst_r_i        ),
    .mst_r_valid_i  ( mst_r_valid_i  ),
    .mst_r_ready_o  ( mst_r_ready_o  )
  );

  // --------------------------------------------------
  // reference model and checks
  // --------------------------------------------------

  // beat data as a mix of port, burst address and beat number
  function automatic data_t expected_r_data(input mst_sel_t port, input addr_t addr,
                                            input int unsigned beat);
    data_t mix;
    mix = addr + data_t'(beat) * 32'd4;
    mix = mix ^ (data_t'(beat) << 20) ^ {8'h3c ^ 8'(port), 24'h0};
    return mix;
  endfunction

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_ar(input string name, input ar_chan_t exp, input ar_chan_t act,
                          input mst_sel_t exp_port, input mst_sel_t act_port);
    if (exp !== act || exp_port !== act_port) begin
      fail_run($sformatf("FAIL %s: expected %h at port %0d, actual %h at port %0d",
                         name, exp, exp_port, act, act_port));
    end
  endtask

  task automatic check_r(input string name, input r_chan_t exp, input r_chan_t act);
    if (exp !== act) begin
      fail_run($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_value(input string name, input int unsigned exp,
                             input int unsigned act);
    if (exp !== act) begin
      fail_run($sformatf("FAIL %s: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  // --------------------------------------------------
  // slave models, one per master port
  // --------------------------------------------------

  for (genvar p = 0; p < NUM_MST; p++) begin : gen_slave
    ar_chan_t    burst_q[$];
    int unsigned beat     = 0;
    logic        taken    = 1'b0;
    logic        ar_rdy_q = 1'b0;
    logic        r_vld_q  = 1'b0;
    r_chan_t     r_q      = '0;

    assign mst_ar_ready_i[p] = ar_rdy_q;
    assign mst_r_valid_i[p]  = r_vld_q;
    assign mst_r_i[p]        = r_q;

    // handshakes seen on the edge, queue bursts in order
    always @(posedge clk_i) begin
      if (mst_ar_valid_o[p] && mst_ar_ready_i[p]) begin
        burst_q.push_back(mst_ar_o);
      end
      if (mst_r_valid_i[p] && mst_r_ready_o[p]) begin
        taken = 1'b1;
        if (r_q.last) begin
          burst_q.delete(0);
          beat = 0;
        end else begin
          beat++;
        end
      end
    end

    // outputs change on the falling edge only
    always @(negedge clk_i) begin
      if (!arst_n_i) begin
        ar_rdy_q = 1'b0;
        r_vld_q  = 1'b0;
      end else begin
        ar_rdy_q = ar_rdy_rnd[p];
        if (taken) begin
          r_vld_q = 1'b0;
          taken   = 1'b0;
        end
        // next beat after a random gap, held beats stay valid
        if (!r_vld_q && burst_q.size() != 0 && !r_hold[p] && r_go_rnd[p]) begin
          r_q.id   = burst_q[0].id;
          r_q.data = expected_r_data(mst_sel_t'(p), burst_q[0].addr, beat);
          r_q.last = (beat == int'(burst_q[0].len));
          r_vld_q  = 1'b1;
        end
      end
    end
  end

  // --------------------------------------------------
  // compare process
  // --------------------------------------------------

  always @(posedge clk_i) begin
    look_id_t    idx;
    axi_id_t     rid;
    int unsigned j;
    r_chan_t     exp_r;
    if (arst_n_i) begin
      // valid at the selected port only, payload untouched
      for (int p = 0; p < NUM_MST; p++) begin
        if (mst_ar_valid_o[p]) begin
          check_ar("ar_route", slv_ar_i, mst_ar_o, slv_ar_sel_i, mst_sel_t'(p));
        end
      end
      // beats taken from each master port
      for (int p = 0; p < NUM_MST; p++) begin
        if (mst_r_valid_i[p] && mst_r_ready_o[p]) begin
          served[p]++;
        end
      end
      // admission rules use counts from before any pop on this edge
      if (slv_ar_valid_i && slv_ar_ready_o) begin
        idx = slv_ar_i.id[`DEMUX_LOOK_BITS-1:0];
        if (outst[idx] != 0 && bound[idx] != slv_ar_sel_i) begin
          fail_run("AR was accepted while its ID was still in flight at another port");
        end
        for (int i = 0; i < NUM_CNT; i++) begin
          if (outst[i] >= MAX_FLIGHT) begin
            fail_run("AR was accepted while an in-flight counter was full");
          end
        end
        rec_ar[rec_cnt]  = slv_ar_i;
        rec_sel[rec_cnt] = slv_ar_sel_i;
        rec_cnt++;
        outst[idx]++;
        bound[idx] = slv_ar_sel_i;
        requested[slv_ar_sel_i] += slv_ar_i.len + 1;
      end
      // R beat traced back to its AR by ID
      if (slv_r_valid_o && slv_r_ready_i) begin
        rid = slv_r_o.id;
        j   = head[rid];
        while (j < rec_cnt && rec_ar[j].id != rid) begin
          j++;
        end
        if (j >= rec_cnt) begin
          fail_run("R beat arrived for an ID without an open burst");
        end else begin
          head[rid]  = j;
          exp_r.id   = rid;
          exp_r.data = expected_r_data(rec_sel[j], rec_ar[j].addr, beat_no[rid]);
          exp_r.last = (beat_no[rid] == int'(rec_ar[j].len));
          check_r("r_beat", exp_r, slv_r_o);
          if (slv_r_o.last) begin
            head[rid]    = j + 1;
            beat_no[rid] = 0;
            outst[rid[`DEMUX_LOOK_BITS-1:0]]--;
          end else begin
            beat_no[rid]++;
          end
        end
      end
    end
  end

  // single source of randomness, seeded once
  initial begin
    void'($urandom(47));
    forever begin
      @(posedge clk_i);
      for (int p = 0; p < NUM_MST; p++) begin
        ar_rdy_rnd[p] = ($urandom_range(3, 0) != 0);
        r_go_rnd[p]   = ($urandom_range(2, 0) != 0);
      end
      @(negedge clk_i);
      slv_r_ready_i = ($urandom_range(3, 0) != 0);
    end
  end

  // --------------------------------------------------
  // stimulus tasks
  // --------------------------------------------------

  task automatic start_ar(input axi_id_t id, input addr_t addr, input len_t len,
                          input mst_sel_t sel);
    @(negedge clk_i);
    slv_ar_i.id    = id;
    slv_ar_i.addr  = addr;
    slv_ar_i.len   = len;
    slv_ar_sel_i   = sel;
    slv_ar_valid_i = 1'b1;
  endtask

  task automatic wait_ar_accept(input int unsigned limit);
    int unsigned n;
    logic        accepted;
    accepted = 1'b0;
    for (n = 0; n < limit && !accepted; n++) begin
      @(posedge clk_i);
      accepted = slv_ar_ready_o;
    end
    if (!accepted) begin
      fail_run("timeout waiting for an AR to be accepted");
    end
    @(negedge clk_i);
    slv_ar_valid_i = 1'b0;
  endtask

  task automatic send_ar(input axi_id_t id, input addr_t addr, input len_t len,
                         input mst_sel_t sel);
    start_ar(id, addr, len, sel);
    wait_ar_accept(1000);
  endtask

  // pending AR must see no ready for this many edges
  task automatic expect_ar_stall(input int unsigned cycles);
    for (int unsigned n = 0; n < cycles; n++) begin
      @(posedge clk_i);
      if (slv_ar_ready_o) begin
        fail_run("AR was accepted while it should have been stalled");
      end
    end
  endtask

  task automatic set_hold(input logic [NUM_MST-1:0] mask);
    @(posedge clk_i);
    r_hold = mask;
  endtask

  // all bursts done, sampled away from the edge the scoreboard updates on
  task automatic wait_idle(input int unsigned limit);
    int unsigned n;
    int unsigned busy;
    busy = 1;
    for (n = 0; n < limit && busy != 0; n++) begin
      @(negedge clk_i);
      busy = 0;
      for (int i = 0; i < NUM_CNT; i++) begin
        busy += outst[i];
      end
    end
    if (busy != 0) begin
      fail_run("timeout waiting for all read bursts to complete");
    end
  endtask

  // --------------------------------------------------
  // scenarios
  // --------------------------------------------------

  initial begin
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    // idle after reset
    @(posedge clk_i);
    check_value("reset_slv_ar_ready", 0, slv_ar_ready_o);
    check_value("reset_slv_r_valid", 0, slv_r_valid_o);
    check_value("reset_mst_ar_valid", 0, mst_ar_valid_o);
    check_value("reset_mst_r_ready", 0, mst_r_ready_o);

    // mixed traffic, ports change every 8 requests so IDs collide across ports
    for (int unsigned i = 0; i < 64; i++) begin
      send_ar(axi_id_t'((i * 5 + 3) % NUM_ID), 32'h4000_0000 + i * 32'h100,
              len_t'((i * 3) % 8), mst_sel_t'((i + i / 8) % NUM_MST));
    end
    wait_idle(4000);

    // same index, same port goes through, other port waits for the drain
    set_hold(4'b0001);
    send_ar(4'h1, 32'h0000_1000, 4'd2, 2'd0);
    send_ar(4'h5, 32'h0000_2000, 4'd1, 2'd0);
    start_ar(4'h9, 32'h0000_3000, 4'd0, 2'd2);
    expect_ar_stall(24);
    set_hold(4'b0000);
    wait_ar_accept(1000);
    wait_idle(1000);

    // seven bursts on one index fill its counter
    set_hold(4'b0010);
    for (int unsigned k = 0; k < MAX_FLIGHT; k++) begin
      send_ar(axi_id_t'(3 + 4 * (k % 4)), 32'h0001_0000 + k * 32'h40, 4'd0, 2'd1);
    end
    start_ar(4'h0, 32'h0002_0000, 4'd1, 2'd3);
    expect_ar_stall(24);
    set_hold(4'b0000);
    wait_ar_accept(1000);
    wait_idle(1000);

    // every port returns data at once
    set_hold(4'b1111);
    for (int unsigned p = 0; p < NUM_MST; p++) begin
      for (int unsigned k = 0; k < 3; k++) begin
        send_ar(axi_id_t'(p + 4 * k), 32'h0800_0000 + p * 32'h1000 + k * 32'h80,
                4'd3, mst_sel_t'(p));
      end
    end
    set_hold(4'b0000);
    wait_idle(2000);

    for (int p = 0; p < NUM_MST; p++) begin
      check_value($sformatf("beats_port%0d", p), requested[p], served[p]);
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+source
source/demux_pkg.sv
source/ar_id_tracker.sv
source/ar_route_ctrl.sv
source/r_rr_arbiter.sv
source/read_demux_top.sv
sim/tb_read_demux.sv

// File: Bender.yml
package:
  name: read_demux

sources:
  - target: rtl
    include_dirs:
      - source
    files:
      - source/demux_pkg.sv
      - source/ar_id_tracker.sv
      - source/ar_route_ctrl.sv
      - source/r_rr_arbiter.sv
      - source/read_demux_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - sim/tb_read_demux.sv
